// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_llc_core
FILELIST  = llc_lite.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

# build, run and look for the pass message in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== llc_lite.f ====
src/llc_pkg.sv
src/llc_tag_store.sv
src/llc_line_store.sv
src/llc_controller.sv
src/llc_core.sv
testbench/llc_core_sva.sv
testbench/tb_llc_core.sv

// ==== src/llc_controller.sv ====
// single-issue cache controller FSM
// request accept, hit and miss handling, memory and response channels
`timescale 1ns/1ps

module llc_controller (
    input  logic                 clk,
    input  logic                 rst,
    // requester side
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  llc_pkg::cpu_req_t    req_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output llc_pkg::cpu_rsp_t    rsp_o,
    // memory side
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output llc_pkg::mem_req_t    mem_req_o,
    input  logic                 mem_rsp_valid_i,
    output logic                 mem_rsp_ready_o,
    input  llc_pkg::mem_rsp_t    mem_rsp_i,
    // store side
    output logic                 lookup_o,
    output llc_pkg::line_addr_t  addr_o,
    input  llc_pkg::tag_result_t tag_result_i,
    input  llc_pkg::line_t       lines_i [llc_pkg::LLC_WAYS],
    output logic                 tag_wr_o,
    output logic                 line_wr_o,
    output llc_pkg::llc_way_t    wr_way_o,
    output logic                 wr_dirty_o,
    output llc_pkg::line_t       wr_line_o
);

    llc_pkg::llc_state_e state_q;
    llc_pkg::llc_state_e state_d;

    llc_pkg::cpu_req_t req_q;
    llc_pkg::cpu_rsp_t rsp_q;
    logic              rsp_valid_q;

    logic              rsp_load;
    llc_pkg::line_t    rsp_line;
    llc_pkg::line_t    fill_line;
    llc_pkg::line_t    victim_line;
    logic              rsp_fire;

    assign req_ready_o     = (state_q == llc_pkg::IDLE);
    assign mem_rsp_ready_o = (state_q == llc_pkg::FILL_WAIT);
    assign mem_req_valid_o = (state_q == llc_pkg::WRITEBACK) || (state_q == llc_pkg::FILL_REQ);
    assign rsp_valid_o     = rsp_valid_q;
    assign rsp_o           = rsp_q;
    assign rsp_fire        = rsp_valid_q && rsp_ready_i;

    // both stores see the held request address
    assign lookup_o = (state_q == llc_pkg::LOOKUP);
    assign addr_o   = req_q.addr;

    assign victim_line = lines_i[tag_result_i.victim_way];
    // write miss merges the write data over the fetched word
    assign fill_line   = req_q.write ? req_q.data : mem_rsp_i.data;

    // memory payload built from registered state, stable while waiting
    always_comb begin
        if (state_q == llc_pkg::WRITEBACK) begin
            mem_req_o.write = 1'b1;
            mem_req_o.addr  = {tag_result_i.victim_tag, req_q.addr[llc_pkg::LLC_SET_BITS-1:0]};
            mem_req_o.data  = victim_line;
        end else begin
            mem_req_o.write = 1'b0;
            mem_req_o.addr  = req_q.addr;
            mem_req_o.data  = '0;
        end
    end

    always_comb begin
        state_d    = state_q;
        tag_wr_o   = 1'b0;
        line_wr_o  = 1'b0;
        wr_way_o   = tag_result_i.hit_way;
        wr_dirty_o = 1'b0;
        wr_line_o  = req_q.data;
        rsp_load   = 1'b0;
        rsp_line   = lines_i[tag_result_i.hit_way];
        case (state_q)
            llc_pkg::IDLE: begin
                if (req_valid_i) begin
                    state_d = llc_pkg::LOOKUP;
                end
            end
            llc_pkg::LOOKUP: begin
                state_d = llc_pkg::PROCESS;
            end
            llc_pkg::PROCESS: begin
                if (tag_result_i.hit) begin
                    rsp_load = 1'b1;
                    if (req_q.write) begin
                        tag_wr_o   = 1'b1;
                        line_wr_o  = 1'b1;
                        wr_dirty_o = 1'b1;
                        rsp_line   = req_q.data;
                    end
                    state_d = llc_pkg::RESPOND;
                end else if (tag_result_i.victim_valid && tag_result_i.victim_dirty) begin
                    state_d = llc_pkg::WRITEBACK;
                end else begin
                    state_d = llc_pkg::FILL_REQ;
                end
            end
            llc_pkg::WRITEBACK: begin
                if (mem_req_ready_i) begin
                    state_d = llc_pkg::FILL_REQ;
                end
            end
            llc_pkg::FILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = llc_pkg::FILL_WAIT;
                end
            end
            llc_pkg::FILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    // refill into the victim way
                    tag_wr_o   = 1'b1;
                    line_wr_o  = 1'b1;
                    wr_way_o   = tag_result_i.victim_way;
                    wr_dirty_o = req_q.write;
                    wr_line_o  = fill_line;
                    rsp_load   = 1'b1;
                    rsp_line   = fill_line;
                    state_d    = llc_pkg::RESPOND;
                end
            end
            llc_pkg::RESPOND: begin
                if (rsp_fire) begin
                    state_d = llc_pkg::IDLE;
                end
            end
            default: begin
                state_d = llc_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= llc_pkg::IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // response register stage, valid one cycle into RESPOND
            if (rsp_fire) begin
                rsp_valid_q <= 1'b0;
            end else if (state_q == llc_pkg::RESPOND) begin
                rsp_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (rsp_load) begin
            rsp_q.data <= rsp_line;
        end
    end

endmodule

// ==== src/llc_core.sv ====
// llc_lite top level
// tag store, line store and controller
`timescale 1ns/1ps

module llc_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_req_valid_i,
    output logic              cpu_req_ready_o,
    input  llc_pkg::cpu_req_t cpu_req_i,
    output logic              cpu_rsp_valid_o,
    input  logic              cpu_rsp_ready_i,
    output llc_pkg::cpu_rsp_t cpu_rsp_o,
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output llc_pkg::mem_req_t mem_req_o,
    input  logic              mem_rsp_valid_i,
    output logic              mem_rsp_ready_o,
    input  llc_pkg::mem_rsp_t mem_rsp_i
);

    logic                 lookup;
    llc_pkg::line_addr_t  addr;
    llc_pkg::tag_result_t tag_result;
    llc_pkg::line_t       lines [llc_pkg::LLC_WAYS];
    logic                 tag_wr;
    logic                 line_wr;
    llc_pkg::llc_way_t    wr_way;
    logic                 wr_dirty;
    llc_pkg::line_t       wr_line;

    llc_tag_store tag_store_u (
        .clk        (clk),
        .rst        (rst),
        .lookup_i   (lookup),
        .addr_i     (addr),
        .tag_wr_i   (tag_wr),
        .wr_way_i   (wr_way),
        .wr_dirty_i (wr_dirty),
        .result_o   (tag_result)
    );

    // line store is indexed by the set field only
    llc_line_store line_store_u (
        .clk       (clk),
        .lookup_i  (lookup),
        .set_i     (addr[llc_pkg::LLC_SET_BITS-1:0]),
        .line_wr_i (line_wr),
        .wr_way_i  (wr_way),
        .wr_line_i (wr_line),
        .lines_o   (lines)
    );

    llc_controller controller_u (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (cpu_req_valid_i),
        .req_ready_o     (cpu_req_ready_o),
        .req_i           (cpu_req_i),
        .rsp_valid_o     (cpu_rsp_valid_o),
        .rsp_ready_i     (cpu_rsp_ready_i),
        .rsp_o           (cpu_rsp_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_i       (mem_rsp_i),
        .lookup_o        (lookup),
        .addr_o          (addr),
        .tag_result_i    (tag_result),
        .lines_i         (lines),
        .tag_wr_o        (tag_wr),
        .line_wr_o       (line_wr),
        .wr_way_o        (wr_way),
        .wr_dirty_o      (wr_dirty),
        .wr_line_o       (wr_line)
    );

endmodule

// ==== src/llc_line_store.sv ====
// line data array
// registered read of all ways in a set, single-way write
`timescale 1ns/1ps

module llc_line_store (
    input  logic              clk,
    input  logic              lookup_i,
    input  llc_pkg::llc_set_t set_i,
    input  logic              line_wr_i,
    input  llc_pkg::llc_way_t wr_way_i,
    input  llc_pkg::line_t    wr_line_i,
    output llc_pkg::line_t    lines_o [llc_pkg::LLC_WAYS]
);

    // one word per way and set
    llc_pkg::line_t data_q [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];

    // read register, holds the whole set
    llc_pkg::line_t rd_q [llc_pkg::LLC_WAYS];

    // write port
    always_ff @(posedge clk) begin
        if (line_wr_i) begin
            data_q[set_i][wr_way_i] <= wr_line_i;
        end
    end

    // read port
    // every way is captured so hit line and victim line
    // both come from this single read
    always_ff @(posedge clk) begin
        if (lookup_i) begin
            for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
                rd_q[w] <= data_q[set_i][w];
            end
        end
    end

    // read data holds until the next lookup
    always_comb begin
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            lines_o[w] = rd_q[w];
        end
    end

endmodule

// ==== src/llc_pkg.sv ====
// cache geometry, vector types, channel structs and controller states
// shared by the llc_lite design and its testbench

package llc_pkg;

    // 4 ways, 16 sets, one word per line
    localparam int LLC_WAYS      = 4;
    localparam int LLC_SETS      = 16;
    localparam int LLC_SET_BITS  = 4;
    localparam int LLC_TAG_BITS  = 8;
    localparam int LLC_WAY_BITS  = 2;
    localparam int LLC_LINE_BITS = 32;

    // line address, tag above set
    typedef logic [LLC_TAG_BITS+LLC_SET_BITS-1:0] line_addr_t;
    typedef logic [LLC_SET_BITS-1:0]              llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]              llc_tag_t;
    typedef logic [LLC_WAY_BITS-1:0]              llc_way_t;
    typedef logic [LLC_LINE_BITS-1:0]             line_t;
    typedef logic [LLC_WAYS-1:0]                  way_mask_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      data;
    } cpu_req_t;

    typedef struct packed {
        line_t data;
    } cpu_rsp_t;

    // write flag set only for a write-back
    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      data;
    } mem_req_t;

    typedef struct packed {
        line_t data;
    } mem_rsp_t;

    // registered lookup outcome of the tag store
    typedef struct packed {
        logic     hit;
        llc_way_t hit_way;
        llc_way_t victim_way;
        logic     victim_valid;
        logic     victim_dirty;
        llc_tag_t victim_tag;
    } tag_result_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        PROCESS,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } llc_state_e;

endpackage

// ==== src/llc_tag_store.sv ====
// valid, dirty and tag arrays with hit detection
// and one round-robin victim pointer per set
`timescale 1ns/1ps

module llc_tag_store (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 lookup_i,
    input  llc_pkg::line_addr_t  addr_i,
    input  logic                 tag_wr_i,
    input  llc_pkg::llc_way_t    wr_way_i,
    input  logic                 wr_dirty_i,
    output llc_pkg::tag_result_t result_o
);

    // per-set state, one bit per way
    llc_pkg::way_mask_t valid_q  [llc_pkg::LLC_SETS];
    llc_pkg::way_mask_t dirty_q  [llc_pkg::LLC_SETS];
    llc_pkg::llc_way_t  victim_q [llc_pkg::LLC_SETS];
    llc_pkg::llc_tag_t  tag_q    [llc_pkg::LLC_SETS][llc_pkg::LLC_WAYS];

    llc_pkg::llc_set_t    set;
    llc_pkg::llc_tag_t    tag;
    llc_pkg::llc_way_t    victim_way;
    logic                 hit;
    llc_pkg::llc_way_t    hit_way;
    llc_pkg::tag_result_t lookup_res;
    llc_pkg::tag_result_t result_q;

    assign set        = addr_i[llc_pkg::LLC_SET_BITS-1:0];
    assign tag        = addr_i[llc_pkg::LLC_SET_BITS +: llc_pkg::LLC_TAG_BITS];
    assign victim_way = victim_q[set];

    // compare the request tag against every valid way
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < llc_pkg::LLC_WAYS; w++) begin
            if (valid_q[set][w] && (tag_q[set][w] == tag)) begin
                hit     = 1'b1;
                hit_way = llc_pkg::llc_way_t'(w);
            end
        end
    end

    // victim state travels with the hit result
    always_comb begin
        lookup_res.hit          = hit;
        lookup_res.hit_way      = hit_way;
        lookup_res.victim_way   = victim_way;
        lookup_res.victim_valid = valid_q[set][victim_way];
        lookup_res.victim_dirty = dirty_q[set][victim_way];
        lookup_res.victim_tag   = tag_q[set][victim_way];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::LLC_SETS; s++) begin
                valid_q[s]  <= '0;
                dirty_q[s]  <= '0;
                victim_q[s] <= '0;
            end
            result_q <= '0;
        end else begin
            if (lookup_i) begin
                result_q <= lookup_res;
            end
            if (tag_wr_i) begin
                valid_q[set][wr_way_i] <= 1'b1;
                dirty_q[set][wr_way_i] <= wr_dirty_i;
                // pointer moves on once its way is refilled
                if (wr_way_i == victim_way) begin
                    victim_q[set] <= victim_way + llc_pkg::llc_way_t'(1);
                end
            end
        end
    end

    // tags are only trusted behind a valid bit
    always_ff @(posedge clk) begin
        if (tag_wr_i) begin
            tag_q[set][wr_way_i] <= tag;
        end
    end

    assign result_o = result_q;

endmodule

// ==== testbench/llc_core_sva.sv ====
// concurrent assertions on the llc_core channels
// reset values, payload hold under back-pressure, request gating
`timescale 1ns/1ps

module llc_core_sva (
    input logic              clk,
    input logic              rst,
    input logic              cpu_req_valid_i,
    input logic              cpu_req_ready_o,
    input logic              cpu_rsp_valid_o,
    input logic              cpu_rsp_ready_i,
    input llc_pkg::cpu_rsp_t cpu_rsp_o,
    input logic              mem_req_valid_o,
    input logic              mem_req_ready_i,
    input llc_pkg::mem_req_t mem_req_o,
    input logic              mem_rsp_ready_o
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    reset_values: assert property (@(posedge clk)
        !rst |=> (cpu_req_ready_o && !cpu_rsp_valid_o && !mem_req_valid_o && !mem_rsp_ready_o))
        else begin
            fail_count++;
            $error("channel outputs not at their reset values");
        end

    rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        (cpu_rsp_valid_o && !cpu_rsp_ready_i) |=> (cpu_rsp_valid_o && $stable(cpu_rsp_o)))
        else begin
            fail_count++;
            $error("cpu response dropped or changed while stalled");
        end

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
        else begin
            fail_count++;
            $error("memory request dropped or changed while stalled");
        end

    // one request in flight
    req_closed_after_accept: assert property (@(posedge clk) disable iff (!rst)
        (cpu_req_valid_i && cpu_req_ready_o) |=> !cpu_req_ready_o)
        else begin
            fail_count++;
            $error("cpu request ready stayed high after an accept");
        end

    req_reopen_after_rsp: assert property (@(posedge clk) disable iff (!rst)
        $rose(cpu_req_ready_o) |-> $past(cpu_rsp_valid_o && cpu_rsp_ready_i))
        else begin
            fail_count++;
            $error("cpu request ready rose without a response transfer");
        end

endmodule

bind llc_core llc_core_sva core_sva_u (.*);

// ==== testbench/tb_llc_core.sv ====
// testbench for llc_core with memory model, reference model and watchdog
// directed cases for fill, hit and eviction, then a random mix
`timescale 1ns/1ps

module tb_llc_core;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_REQUESTS = 209;
    localparam int WATCHDOG_NS  = NUM_REQUESTS * 200 * CLK_PERIOD + 1000;

    logic              clk = 1'b0;
    logic              rst = 1'b0;
    logic              cpu_req_valid = 1'b0;
    llc_pkg::cpu_req_t cpu_req = '0;
    logic              cpu_rsp_ready = 1'b0;
    logic              mem_req_ready = 1'b0;
    logic              mem_rsp_valid = 1'b0;
    llc_pkg::mem_rsp_t mem_rsp = '0;
    logic              cpu_req_ready_o;
    logic              cpu_rsp_valid_o;
    llc_pkg::cpu_rsp_t cpu_rsp_o;
    logic              mem_req_valid_o;
    llc_pkg::mem_req_t mem_req_o;
    logic              mem_rsp_ready_o;

    integer seed = 16;
    int     errors = 0;
    int     issued = 0;

    // reference words, and memory behind the cache
    llc_pkg::line_t      ref_mem   [4096];
    llc_pkg::line_t      mem_model [4096];
    logic                written_since_fill [4096];
    llc_pkg::cpu_req_t   cur_req;
    logic                fill_pending;
    int                  fill_delay;
    llc_pkg::line_addr_t fill_addr;
    int                  fill_count;
    int                  wb_count;
    int                  mem_req_count;
    llc_pkg::line_addr_t last_fill_addr;
    llc_pkg::line_addr_t last_wb_addr;
    llc_pkg::line_t      last_wb_data;
    logic                rsp_taken = 1'b0;
    logic                fill_go = 1'b0;

    llc_core dut (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_valid_i (cpu_req_valid),
        .cpu_req_ready_o (cpu_req_ready_o),
        .cpu_req_i       (cpu_req),
        .cpu_rsp_valid_o (cpu_rsp_valid_o),
        .cpu_rsp_ready_i (cpu_rsp_ready),
        .cpu_rsp_o       (cpu_rsp_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .mem_rsp_i       (mem_rsp)
    );

    always #5 clk = ~clk;

    function automatic void check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endfunction

    // handshakes sampled mid-cycle, the transfer follows on the next edge
    always @(negedge clk) begin
        if (rst) begin
            if (cpu_req_valid && cpu_req_ready_o) begin
                cur_req = cpu_req;
            end
            if (cpu_rsp_valid_o && cpu_rsp_ready && cur_req.write) begin
                written_since_fill[cur_req.addr] = 1'b1;
            end
            if (mem_req_valid_o && mem_req_ready) begin
                mem_req_count++;
                if (mem_req_o.write) begin
                    wb_count++;
                    last_wb_addr = mem_req_o.addr;
                    last_wb_data = mem_req_o.data;
                    assert (written_since_fill[mem_req_o.addr]) else begin
                        errors++;
                        $display("write-back at %0t of line %h that was not written since its fill",
                                 $time, mem_req_o.addr);
                    end
                    check_value("mem_req_o.data", mem_req_o.data, ref_mem[mem_req_o.addr]);
                    mem_model[mem_req_o.addr] = mem_req_o.data;
                    written_since_fill[mem_req_o.addr] = 1'b0;
                end else begin
                    fill_count++;
                    last_fill_addr = mem_req_o.addr;
                    fill_addr      = mem_req_o.addr;
                    fill_pending   = 1'b1;
                    fill_delay     = $random(seed) & 3;
                    written_since_fill[mem_req_o.addr] = 1'b0;
                end
            end
            rsp_taken = mem_rsp_valid && mem_rsp_ready_o;
            fill_go   = 1'b0;
            if (!mem_rsp_valid && fill_pending) begin
                if (fill_delay == 0) begin
                    fill_go      = 1'b1;
                    fill_pending = 1'b0;
                end else begin
                    fill_delay--;
                end
            end
        end
    end

    // memory model drive and random back-pressure
    always @(posedge clk) begin
        if (!rst) begin
            for (int a = 0; a < 4096; a++) begin
                mem_model[a] = 32'(a * 3 + 1);
                written_since_fill[a] = 1'b0;
            end
            fill_pending  = 1'b0;
            fill_delay    = 0;
            fill_count    = 0;
            wb_count      = 0;
            mem_req_count = 0;
            mem_req_ready <= 1'b0;
            cpu_rsp_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
        end else begin
            if (rsp_taken) begin
                mem_rsp_valid <= 1'b0;
            end else if (fill_go) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp.data  <= mem_model[fill_addr];
            end
            mem_req_ready <= (($random(seed) & 3) != 0);
            cpu_rsp_ready <= (($random(seed) & 3) != 0);
        end
    end

    // one request, waits for its response; latency counts edges from accept to rsp valid
    task automatic cpu_transfer(input llc_pkg::cpu_req_t req, output llc_pkg::line_t rdata,
                                output int latency);
        cpu_req_valid <= 1'b1;
        cpu_req       <= req;
        @(negedge clk);
        while (!cpu_req_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        issued++;
        latency = 0;
        @(negedge clk);
        while (!cpu_rsp_valid_o) begin
            latency++;
            @(negedge clk);
        end
        while (!cpu_rsp_ready) begin
            @(negedge clk);
        end
        rdata = cpu_rsp_o.data;
        @(posedge clk);
    endtask

    task automatic checked_access(input logic wr, input llc_pkg::line_addr_t addr,
                                  input llc_pkg::line_t wdata, output int latency);
        llc_pkg::cpu_req_t req;
        llc_pkg::line_t    got;
        req.write = wr;
        req.addr  = addr;
        req.data  = wdata;
        cpu_transfer(req, got, latency);
        // writes echo their data
        if (wr) begin
            ref_mem[addr] = wdata;
        end
        check_value("cpu_rsp_o.data", got, ref_mem[addr]);
    endtask

    initial begin
        int                  lat;
        int                  fills_before;
        int                  reqs_before;
        int                  wbs_before;
        logic                rnd_write;
        llc_pkg::line_addr_t rnd_addr;
        llc_pkg::line_addr_t set_addr [5];
        llc_pkg::line_t      set_data [5];
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = 32'(a * 3 + 1);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        // cold read fetches exactly one line
        fills_before = fill_count;
        reqs_before  = mem_req_count;
        checked_access(1'b0, 12'h0A3, '0, lat);
        check_value("fill count", fill_count - fills_before, 1);
        check_value("memory request count", mem_req_count - reqs_before, 1);
        check_value("fill address", 32'(last_fill_addr), 32'h0A3);

        // write miss then read hit
        checked_access(1'b1, 12'h0B7, 32'($random(seed)), lat);
        reqs_before = mem_req_count;
        checked_access(1'b0, 12'h0B7, '0, lat);
        check_value("memory request count", mem_req_count - reqs_before, 0);
        check_value("hit latency", lat, 3);

        // fifth write to set 5 evicts the first line
        for (int i = 0; i < 5; i++) begin
            set_addr[i] = {llc_pkg::llc_tag_t'(8'h10 + i), 4'h5};
            set_data[i] = 32'($random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            checked_access(1'b1, set_addr[i], set_data[i], lat);
        end
        wbs_before = wb_count;
        checked_access(1'b1, set_addr[4], set_data[4], lat);
        check_value("write-back count", wb_count - wbs_before, 1);
        check_value("write-back address", 32'(last_wb_addr), 32'(set_addr[0]));
        check_value("write-back data", last_wb_data, set_data[0]);
        fills_before = fill_count;
        checked_access(1'b0, set_addr[0], '0, lat);
        check_value("fill count", fill_count - fills_before, 1);
        check_value("fill address", 32'(last_fill_addr), 32'(set_addr[0]));

        // random mix, 8 tags over 8 sets
        for (int i = 0; i < 200; i++) begin
            rnd_write = 1'($random(seed) & 1);
            rnd_addr  = {llc_pkg::llc_tag_t'(8'h20 + ($random(seed) & 7)),
                         llc_pkg::llc_set_t'($random(seed) & 7)};
            checked_access(rnd_write, rnd_addr, 32'($random(seed)), lat);
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d checks, %0d assertions over %0d requests",
                 errors, dut.core_sva_u.fail_count, issued);
        if (errors == 0 && dut.core_sva_u.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: no progress after %0d requests", issued);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
